// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test ended without a result"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/csr_unit_tb.sv ====
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();

    localparam logic [31:0] time_base     = 32'h0200_BFF8;
    localparam logic [31:0] hart_value    = 32'h0000_0003;
    localparam int          run_cycles    = 3000;
    localparam logic [31:0] keep_mstatus  = 32'h0000_1888;
    localparam logic [31:0] keep_mtvec    = 32'hFFFF_FFFD;
    localparam logic [31:0] keep_inhibit  = 32'h0000_0005;
    localparam logic [31:0] keep_dcsr     = 32'h0000_8E04;
    localparam logic [31:0] dcsr_constant = 32'h4000_0003;

    logic        clk   = 1'b0;
    logic        rst_n = 1'b0;
    logic [11:0] addr;
    logic [2:0]  f3;
    logic [31:0] reg_in;
    logic [31:0] imm_in;
    logic [4:0]  rs;
    logic        write;
    logic        debug;
    logic        retire;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_we;
    logic        bus_re;
    logic [31:0] csr_out;
    logic        invalid;
    logic        timeint;
    logic [31:0] bus_rdata;
    logic        bus_hit;

    // reference state that every rising edge updates
    logic [31:0] m_mstatus, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
    logic [31:0] m_inhibit, m_dcsr, m_dpc, m_rdata;
    logic [63:0] m_mcycle, m_minstret, m_mtime, m_mtimecmp;
    logic [31:0] rng_state;

    csr_unit #(
        .time_base(time_base),
        .hart_id  (hart_value)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .f3       (f3),
        .reg_in   (reg_in),
        .imm_in   (imm_in),
        .rs       (rs),
        .write    (write),
        .debug    (debug),
        .retire   (retire),
        .bus_addr (bus_addr),
        .bus_wdata(bus_wdata),
        .bus_we   (bus_we),
        .bus_re   (bus_re),
        .csr_out  (csr_out),
        .invalid  (invalid),
        .timeint  (timeint),
        .bus_rdata(bus_rdata),
        .bus_hit  (bus_hit)
    );

    always #50 clk = ~clk;

    initial begin
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [11:0] pick_addr(input logic [3:0] idx);
        case (idx)
            4'd0:    return addr_mstatus;
            4'd1:    return addr_mcountinhibit;
            4'd2:    return addr_mtvec;
            4'd3:    return addr_mscratch;
            4'd4:    return addr_mepc;
            4'd5:    return addr_mcause;
            4'd6:    return addr_mtval;
            4'd7:    return addr_dcsr;
            4'd8:    return addr_dpc;
            4'd9:    return addr_mcycle;
            4'd10:   return addr_minstret;
            4'd11:   return addr_mcycleh;
            4'd12:   return addr_minstreth;
            4'd13:   return addr_mvendorid;
            default: return addr_mhartid;
        endcase
    endfunction

    function automatic logic csr_known(input logic [11:0] a);
        for (int i = 0; i < 15; i++) begin
            if (pick_addr(4'(i)) == a) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        case (a)
            addr_mstatus:       return m_mstatus;
            addr_mcountinhibit: return m_inhibit;
            addr_mtvec:         return m_mtvec;
            addr_mscratch:      return m_mscratch;
            addr_mepc:          return m_mepc;
            addr_mcause:        return m_mcause;
            addr_mtval:         return m_mtval;
            addr_dcsr:          return m_dcsr | dcsr_constant;
            addr_dpc:           return m_dpc;
            addr_mcycle:        return m_mcycle[31:0];
            addr_mcycleh:       return m_mcycle[63:32];
            addr_minstret:      return m_minstret[31:0];
            addr_minstreth:     return m_minstret[63:32];
            addr_mhartid:       return hart_value;
            default:            return 32'd0;
        endcase
    endfunction

    function automatic logic write_suppressed();
        logic zero_src;
        zero_src = f3[2] ? (imm_in == 32'd0) : (rs == 5'd0);
        return (f3[1:0] == 2'b10 || f3[1:0] == 2'b11) && zero_src;
    endfunction

    function automatic logic expect_invalid();
        return !csr_known(addr) || (!write_suppressed() && addr[11:10] == 2'b11) ||
               (addr[11:4] == 8'h7B && !debug);
    endfunction

    function automatic logic in_window(input logic [31:0] a);
        logic [31:0] aligned;
        aligned = {a[31:2], 2'b00};
        return aligned >= time_base && aligned < time_base + 32'd16;
    endfunction

    function automatic logic [31:0] timer_word(input logic [1:0] idx);
        case (idx)
            2'd0:    return m_mtime[31:0];
            2'd1:    return m_mtime[63:32];
            2'd2:    return m_mtimecmp[31:0];
            default: return m_mtimecmp[63:32];
        endcase
    endfunction

    task automatic model_reset();
        m_mstatus  = 32'h0000_1800;
        m_mtvec    = 32'd0;
        m_mscratch = 32'd0;
        m_mepc     = 32'd0;
        m_mcause   = 32'd0;
        m_mtval    = 32'd0;
        m_inhibit  = 32'd0;
        m_dcsr     = 32'd0;
        m_dpc      = 32'd0;
        m_rdata    = 32'd0;
        m_mcycle   = 64'd0;
        m_minstret = 64'd0;
        m_mtime    = 64'd0;
        m_mtimecmp = '1;
    endtask

    task automatic model_step();
        logic [31:0] old_value;
        logic [31:0] operand;
        logic [31:0] new_value;
        logic [31:0] offset;
        logic        wen;
        logic        stop_cnt;
        logic        stop_tm;
        logic        hit;

        old_value = model_read(addr);
        operand   = f3[2] ? imm_in : reg_in;
        case (f3[1:0])
            2'b10:   new_value = old_value | operand;
            2'b11:   new_value = old_value & ~operand;
            default: new_value = operand;
        endcase
        wen      = write && !write_suppressed() && !expect_invalid();
        stop_cnt = debug && m_dcsr[10];
        stop_tm  = debug && m_dcsr[9];

        if (wen && addr == addr_mcycle) begin
            m_mcycle[31:0] = new_value;
        end else if (wen && addr == addr_mcycleh) begin
            m_mcycle[63:32] = new_value;
        end else if (!m_inhibit[0] && !stop_cnt) begin
            m_mcycle = m_mcycle + 64'd1;
        end
        if (wen && addr == addr_minstret) begin
            m_minstret[31:0] = new_value;
        end else if (wen && addr == addr_minstreth) begin
            m_minstret[63:32] = new_value;
        end else if (retire && !m_inhibit[2] && !stop_cnt) begin
            m_minstret = m_minstret + 64'd1;
        end

        offset = {bus_addr[31:2], 2'b00} - time_base; // word index sits in bits 3:2
        hit    = in_window(bus_addr);
        if (bus_re && hit) begin
            m_rdata = timer_word(offset[3:2]);
        end
        if (!(bus_we && hit && !offset[3]) && !stop_tm) begin
            m_mtime = m_mtime + 64'd1;
        end
        if (bus_we && hit) begin
            case (offset[3:2])
                2'd0:    m_mtime[31:0] = bus_wdata;
                2'd1:    m_mtime[63:32] = bus_wdata;
                2'd2:    m_mtimecmp[31:0] = bus_wdata;
                default: m_mtimecmp[63:32] = bus_wdata;
            endcase
        end

        if (wen) begin
            case (addr)
                addr_mstatus:       m_mstatus = new_value & keep_mstatus;
                addr_mcountinhibit: m_inhibit = new_value & keep_inhibit;
                addr_mtvec:         m_mtvec = new_value & keep_mtvec;
                addr_mscratch:      m_mscratch = new_value;
                addr_mepc:          m_mepc = new_value;
                addr_mcause:        m_mcause = new_value;
                addr_mtval:         m_mtval = new_value;
                addr_dcsr:          m_dcsr = new_value & keep_dcsr;
                addr_dpc:           m_dpc = new_value;
                default: ;
            endcase
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs();
        check_value("csr_out", csr_out, model_read(addr));
        check_value("invalid", {31'd0, invalid}, {31'd0, expect_invalid()});
        check_value("timeint", {31'd0, timeint}, {31'd0, m_mtime >= m_mtimecmp});
        check_value("bus_hit", {31'd0, bus_hit}, {31'd0, in_window(bus_addr)});
        check_value("bus_rdata", bus_rdata, m_rdata);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic drive_idle();
        addr      = addr_mscratch;
        f3        = 3'b010; // csrrs with rs 0 only reads
        reg_in    = 32'd0;
        imm_in    = 32'd0;
        rs        = 5'd0;
        write     = 1'b0;
        debug     = 1'b0;
        retire    = 1'b0;
        bus_addr  = 32'd0;
        bus_wdata = 32'd0;
        bus_we    = 1'b0;
        bus_re    = 1'b0;
    endtask

    task automatic expect_reset_read(input logic [11:0] a, input logic [31:0] value);
        drive_idle();
        addr  = a;
        debug = (a[11:4] == 8'h7B);
        next_cycle();
        check_value("csr_out", csr_out, value);
    endtask

    task automatic write_dcsr(input logic [2:0] op, input logic [31:0] bits);
        drive_idle();
        debug  = 1'b1;
        addr   = addr_dcsr;
        f3     = op;
        rs     = 5'd1;
        reg_in = bits;
        write  = 1'b1;
        next_cycle();
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        drive_idle();
        bus_addr  = a;
        bus_wdata = d;
        bus_we    = 1'b1;
        next_cycle();
    endtask

    task automatic check_stoptime();
        logic [31:0] frozen;
        write_dcsr(3'b010, 32'h0000_0200);
        frozen = m_mtime[31:0]; // last count before the halt takes hold
        drive_idle();
        debug    = 1'b1;
        bus_addr = time_base;
        bus_re   = 1'b1;
        next_cycle();
        check_value("bus_rdata", bus_rdata, frozen);
        repeat (3) next_cycle();
        check_value("bus_rdata", bus_rdata, frozen); // mtime held while halted
        write_dcsr(3'b011, 32'h0000_0200);
    endtask

    task automatic check_compare();
        logic [63:0] target;
        int          waited;
        target = m_mtime + 64'd20;
        bus_write(time_base + 32'd8, target[31:0]);
        bus_write(time_base + 32'd12, target[63:32]);
        drive_idle();
        waited = 0;
        while (!timeint && waited < 100) begin
            next_cycle();
            waited++;
        end
        assert (timeint) else begin
            $display("timer interrupt did not rise within 100 cycles of setting mtimecmp");
            stop_with_failure();
        end
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] s;
        r = next_random();
        s = next_random();
        if (r[2:0] == 3'd0) begin
            addr = r[14:3];
        end else begin
            addr = pick_addr(4'(r[6:3] % 4'd15));
        end
        f3     = {r[7], (r[9:8] == 2'b00) ? 2'b01 : r[9:8]};
        rs     = (r[11:10] == 2'b00) ? 5'd0 : r[16:12];
        imm_in = (r[18:17] == 2'b00) ? 32'd0 : {27'd0, r[23:19]};
        reg_in = r[24] ? s : {28'hFFF_FFFF, s[3:0]}; // near wrap so counters carry soon
        write  = r[25] | r[26];
        debug  = r[27] & r[28];
        retire = r[29];
        s = next_random();
        case (s[2:0])
            3'd0, 3'd1, 3'd2: bus_addr = time_base + {26'd0, s[4:3], 2'b00};
            3'd3:             bus_addr = time_base + {28'd0, s[6:3]};
            3'd4:             bus_addr = time_base - 32'd4;
            3'd5:             bus_addr = time_base + 32'd16;
            default:          bus_addr = next_random();
        endcase
        bus_we = s[7] & s[8];
        bus_re = s[9];
        if (s[10]) begin
            bus_wdata = next_random();
        end else if (bus_addr[2]) begin
            bus_wdata = m_mtime[63:32]; // odd words are the high halves
        end else begin
            bus_wdata = m_mtime[31:0] + {27'd0, s[15:11]};
        end
    endtask

    initial begin
        int waited;
        rng_state = 32'h00da_7617;
        drive_idle();
        waited = 0;
        while (!rst_n && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        assert (rst_n) else begin
            $display("reset was not released within 10 cycles");
            stop_with_failure();
        end
        next_cycle();

        expect_reset_read(addr_mstatus, 32'h0000_1800);
        expect_reset_read(addr_mtvec, 32'd0);
        expect_reset_read(addr_mscratch, 32'd0);
        expect_reset_read(addr_mepc, 32'd0);
        expect_reset_read(addr_mcause, 32'd0);
        expect_reset_read(addr_mtval, 32'd0);
        expect_reset_read(addr_mcountinhibit, 32'd0);
        expect_reset_read(addr_dcsr, 32'h4000_0003);
        expect_reset_read(addr_dpc, 32'd0);
        expect_reset_read(addr_mvendorid, 32'd0);
        expect_reset_read(addr_mhartid, hart_value);
        check_value("timeint", {31'd0, timeint}, 32'd0);
        check_value("bus_rdata", bus_rdata, 32'd0);

        check_stoptime();
        check_compare();

        for (int i = 0; i < run_cycles; i++) begin
            drive_random();
            next_cycle();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/csr_counters.sv ====
`default_nettype none

module csr_counters import csr_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [xlen-1:0]   wr_value,
    input  wire counter_sel_e      wr_sel,
    input  wire logic              retire,
    input  wire logic              inhibit_cy,
    input  wire logic              inhibit_ir,
    input  wire logic              stop_count,
    output logic      [2*xlen-1:0] mcycle,
    output logic      [2*xlen-1:0] minstret
);
    logic cycle_inc;
    logic instret_inc;

    assign cycle_inc   = !inhibit_cy && !stop_count;
    assign instret_inc = retire && !inhibit_ir && !stop_count;

    // a software write to either half wins over the increment of the whole counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle <= '0;
        end else begin
            case (wr_sel)
                cnt_mcycle:  mcycle[xlen-1:0]      <= wr_value;
                cnt_mcycleh: mcycle[2*xlen-1:xlen] <= wr_value;
                default: begin
                    if (cycle_inc) begin
                        mcycle <= mcycle + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            minstret <= '0;
        end else begin
            case (wr_sel)
                cnt_minstret:  minstret[xlen-1:0]      <= wr_value;
                cnt_minstreth: minstret[2*xlen-1:xlen] <= wr_value;
                default: begin
                    if (instret_inc) begin
                        minstret <= minstret + 1'b1; // carry runs into the high word
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    parameter int xlen     = 32;
    parameter int csr_alen = 12;

    // machine registers
    localparam logic [csr_alen-1:0] addr_mstatus       = 12'h300;
    localparam logic [csr_alen-1:0] addr_mcountinhibit = 12'h320;
    localparam logic [csr_alen-1:0] addr_mtvec         = 12'h305;
    localparam logic [csr_alen-1:0] addr_mscratch      = 12'h340;
    localparam logic [csr_alen-1:0] addr_mepc          = 12'h341;
    localparam logic [csr_alen-1:0] addr_mcause        = 12'h342;
    localparam logic [csr_alen-1:0] addr_mtval         = 12'h343;
    localparam logic [csr_alen-1:0] addr_dcsr          = 12'h7B0;
    localparam logic [csr_alen-1:0] addr_dpc           = 12'h7B1;
    localparam logic [csr_alen-1:0] addr_mcycle        = 12'hB00;
    localparam logic [csr_alen-1:0] addr_minstret      = 12'hB02;
    localparam logic [csr_alen-1:0] addr_mcycleh       = 12'hB80;
    localparam logic [csr_alen-1:0] addr_minstreth     = 12'hB82;
    localparam logic [csr_alen-1:0] addr_mvendorid     = 12'hF11;
    localparam logic [csr_alen-1:0] addr_mhartid       = 12'hF14;

    typedef enum logic [1:0] {
        op_rw = 2'b01,
        op_rs = 2'b10,
        op_rc = 2'b11
    } csr_op_e;

    typedef enum logic [2:0] {
        cnt_none,
        cnt_mcycle,
        cnt_mcycleh,
        cnt_minstret,
        cnt_minstreth
    } counter_sel_e;

    localparam logic [4:0] dcsr_stopcount    = 5'd10;
    localparam logic [4:0] dcsr_stoptime     = 5'd9;
    localparam logic [4:0] mcountinhibit_cy  = 5'd0;
    localparam logic [4:0] mcountinhibit_ir  = 5'd2;

    localparam logic [xlen-1:0] mstatus_mask       = 32'h0000_1888; // MIE, MPIE and MPP
    localparam logic [xlen-1:0] mtvec_mask         = 32'hFFFF_FFFD;
    localparam logic [xlen-1:0] mcountinhibit_mask = 32'h0000_0005;
    localparam logic [xlen-1:0] dcsr_mask          = 32'h0000_8E04; // ebreakm, stop bits, step

    // top two address bits set mark a read-only CSR
    function automatic logic is_read_only(input logic [csr_alen-1:0] a);
        return a[11:10] == 2'b11;
    endfunction

    function automatic logic is_debug_only(input logic [csr_alen-1:0] a);
        return a[11:4] == 8'h7B;
    endfunction

endpackage

`default_nettype wire

// ==== source/csr_regs.sv ====
`default_nettype none

module csr_regs import csr_pkg::*; #(
    parameter logic [xlen-1:0] hart_id = '0
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [csr_alen-1:0] addr,
    input  wire logic [2:0]          f3,
    input  wire logic [xlen-1:0]     reg_in,
    input  wire logic [xlen-1:0]     imm_in,
    input  wire logic [4:0]          rs,
    input  wire logic                write,
    input  wire logic                debug,
    input  wire logic [2*xlen-1:0]   mcycle,
    input  wire logic [2*xlen-1:0]   minstret,
    output logic      [xlen-1:0]     csr_out,
    output logic                     invalid,
    output logic      [xlen-1:0]     wr_value,
    output counter_sel_e             wr_sel,
    output logic                     inhibit_cy,
    output logic                     inhibit_ir,
    output logic                     stop_count,
    output logic                     stop_time
);
    localparam logic [xlen-1:0] mstatus_reset = 32'h0000_1800;
    localparam logic [xlen-1:0] dcsr_fixed    = 32'h4000_0003; // debug version 4, prv machine

    csr_op_e         op;
    logic [xlen-1:0] operand;
    logic [xlen-1:0] new_value;
    logic            src_zero;
    logic            suppress;
    logic            known;
    logic            write_en;

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mscratch_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;
    logic [xlen-1:0] mtval_q;
    logic [xlen-1:0] mcountinhibit_q;
    logic [xlen-1:0] dcsr_q;
    logic [xlen-1:0] dpc_q;

    assign op       = csr_op_e'(f3[1:0]);
    assign operand  = f3[2] ? imm_in : reg_in;
    assign src_zero = f3[2] ? (imm_in == '0) : (rs == '0);
    assign suppress = ((op == op_rs) || (op == op_rc)) && src_zero; // set or clear with nothing to do

    always_comb begin
        case (op)
            op_rs:   new_value = csr_out | operand;
            op_rc:   new_value = csr_out & ~operand;
            default: new_value = operand;
        endcase
    end

    always_comb begin
        known   = 1'b1;
        csr_out = '0;
        case (addr)
            addr_mstatus:       csr_out = mstatus_q;
            addr_mcountinhibit: csr_out = mcountinhibit_q;
            addr_mtvec:         csr_out = mtvec_q;
            addr_mscratch:      csr_out = mscratch_q;
            addr_mepc:          csr_out = mepc_q;
            addr_mcause:        csr_out = mcause_q;
            addr_mtval:         csr_out = mtval_q;
            addr_dcsr:          csr_out = dcsr_q | dcsr_fixed;
            addr_dpc:           csr_out = dpc_q;
            addr_mcycle:        csr_out = mcycle[xlen-1:0];
            addr_mcycleh:       csr_out = mcycle[2*xlen-1:xlen];
            addr_minstret:      csr_out = minstret[xlen-1:0];
            addr_minstreth:     csr_out = minstret[2*xlen-1:xlen];
            addr_mvendorid:     csr_out = '0;
            addr_mhartid:       csr_out = hart_id;
            default:            known   = 1'b0;
        endcase
    end

    assign invalid  = !known || (!suppress && is_read_only(addr)) ||
                      (is_debug_only(addr) && !debug);
    assign write_en = write && !suppress && !invalid;

    // counter halves live in csr_counters
    assign wr_value = new_value;
    always_comb begin
        wr_sel = cnt_none;
        if (write_en) begin
            case (addr)
                addr_mcycle:    wr_sel = cnt_mcycle;
                addr_mcycleh:   wr_sel = cnt_mcycleh;
                addr_minstret:  wr_sel = cnt_minstret;
                addr_minstreth: wr_sel = cnt_minstreth;
                default:        wr_sel = cnt_none;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_q       <= mstatus_reset;
            mtvec_q         <= '0;
            mscratch_q      <= '0;
            mepc_q          <= '0;
            mcause_q        <= '0;
            mtval_q         <= '0;
            mcountinhibit_q <= '0;
            dcsr_q          <= '0; // fixed fields come from dcsr_fixed
            dpc_q           <= '0;
        end else if (write_en) begin
            case (addr)
                addr_mstatus:       mstatus_q       <= new_value & mstatus_mask;
                addr_mcountinhibit: mcountinhibit_q <= new_value & mcountinhibit_mask;
                addr_mtvec:         mtvec_q         <= new_value & mtvec_mask;
                addr_mscratch:      mscratch_q      <= new_value;
                addr_mepc:          mepc_q          <= new_value;
                addr_mcause:        mcause_q        <= new_value;
                addr_mtval:         mtval_q         <= new_value;
                addr_dcsr:          dcsr_q          <= new_value & dcsr_mask;
                addr_dpc:           dpc_q           <= new_value;
                default: ;
            endcase
        end
    end

    assign inhibit_cy = mcountinhibit_q[mcountinhibit_cy];
    assign inhibit_ir = mcountinhibit_q[mcountinhibit_ir];
    assign stop_count = debug && dcsr_q[dcsr_stopcount];
    assign stop_time  = debug && dcsr_q[dcsr_stoptime];

endmodule

`default_nettype wire

// ==== source/csr_unit.sv ====
`default_nettype none

module csr_unit import csr_pkg::*; #(
    parameter logic [31:0]     time_base = 32'h0200_BFF8,
    parameter logic [xlen-1:0] hart_id   = '0
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [csr_alen-1:0] addr,
    input  wire logic [2:0]          f3,
    input  wire logic [xlen-1:0]     reg_in,
    input  wire logic [xlen-1:0]     imm_in,
    input  wire logic [4:0]          rs,
    input  wire logic                write,
    input  wire logic                debug,
    input  wire logic                retire,
    input  wire logic [31:0]         bus_addr,
    input  wire logic [31:0]         bus_wdata,
    input  wire logic                bus_we,
    input  wire logic                bus_re,
    output logic      [xlen-1:0]     csr_out,
    output logic                     invalid,
    output logic                     timeint,
    output logic      [31:0]         bus_rdata,
    output logic                     bus_hit
);
    logic [xlen-1:0]   wr_value;
    counter_sel_e      wr_sel;
    logic              inhibit_cy;
    logic              inhibit_ir;
    logic              stop_count;
    logic              stop_time;
    logic [2*xlen-1:0] mcycle;
    logic [2*xlen-1:0] minstret;
    logic [4*xlen-1:0] memory;
    logic [xlen-1:0]   data_periph_out;
    logic [3:0]        data_periph_write;

    csr_regs #(
        .hart_id(hart_id)
    ) i_csr_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .f3        (f3),
        .reg_in    (reg_in),
        .imm_in    (imm_in),
        .rs        (rs),
        .write     (write),
        .debug     (debug),
        .mcycle    (mcycle),
        .minstret  (minstret),
        .csr_out   (csr_out),
        .invalid   (invalid),
        .wr_value  (wr_value),
        .wr_sel    (wr_sel),
        .inhibit_cy(inhibit_cy),
        .inhibit_ir(inhibit_ir),
        .stop_count(stop_count),
        .stop_time (stop_time)
    );

    csr_counters i_csr_counters (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_value  (wr_value),
        .wr_sel    (wr_sel),
        .retire    (retire),
        .inhibit_cy(inhibit_cy),
        .inhibit_ir(inhibit_ir),
        .stop_count(stop_count),
        .mcycle    (mcycle),
        .minstret  (minstret)
    );

    machine_timer i_machine_timer (
        .clk              (clk),
        .rst_n            (rst_n),
        .stop_time        (stop_time),
        .data_periph_out  (data_periph_out),
        .data_periph_write(data_periph_write),
        .memory           (memory),
        .timeint          (timeint)
    );

    periph_mem_interface #(
        .base_address(time_base),
        .size_words  (4)
    ) i_periph_mem_interface (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus_addr         (bus_addr),
        .bus_wdata        (bus_wdata),
        .bus_we           (bus_we),
        .bus_re           (bus_re),
        .data_periph_in   (memory),
        .bus_rdata        (bus_rdata),
        .bus_hit          (bus_hit),
        .data_periph_out  (data_periph_out),
        .data_periph_write(data_periph_write)
    );

endmodule

`default_nettype wire

// ==== source/machine_timer.sv ====
`default_nettype none

module machine_timer import csr_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              stop_time,
    input  wire logic [xlen-1:0]   data_periph_out,
    input  wire logic [3:0]        data_periph_write,
    output logic      [4*xlen-1:0] memory,
    output logic                   timeint
);
    logic [2*xlen-1:0] mtime;
    logic [2*xlen-1:0] mtimecmp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime    <= '0;
            mtimecmp <= '1; // no interrupt until software programs a compare
        end else begin
            if (data_periph_write[0]) begin
                mtime[xlen-1:0] <= data_periph_out;
            end
            if (data_periph_write[1]) begin
                mtime[2*xlen-1:xlen] <= data_periph_out;
            end
            if (data_periph_write[1:0] == 2'b00 && !stop_time) begin
                mtime <= mtime + 1'b1;
            end
            if (data_periph_write[2]) begin
                mtimecmp[xlen-1:0] <= data_periph_out;
            end
            if (data_periph_write[3]) begin
                mtimecmp[2*xlen-1:xlen] <= data_periph_out;
            end
        end
    end

    assign memory  = {mtimecmp, mtime}; // mtime at offset 0, mtimecmp at offset 8
    assign timeint = mtime >= mtimecmp;

endmodule

`default_nettype wire

// ==== source/periph_mem_interface.sv ====
`default_nettype none

module periph_mem_interface import csr_pkg::*; #(
    parameter logic [31:0] base_address = 32'h0200_BFF8,
    parameter int          size_words   = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [31:0]                  bus_addr,
    input  wire logic [31:0]                  bus_wdata,
    input  wire logic                         bus_we,
    input  wire logic                         bus_re,
    input  wire logic [xlen*size_words-1:0]   data_periph_in,
    output logic      [31:0]                  bus_rdata,
    output logic                              bus_hit,
    output logic      [xlen-1:0]              data_periph_out,
    output logic      [size_words-1:0]        data_periph_write
);
    localparam int idx_w = (size_words > 1) ? $clog2(size_words) : 1;

    logic [31:0]      offset;
    logic [idx_w-1:0] word_idx;

    // addresses below the base wrap to a large offset and miss
    assign offset   = bus_addr - base_address;
    assign bus_hit  = {2'b00, offset[31:2]} < 32'(size_words);
    assign word_idx = offset[idx_w+1:2];

    assign data_periph_out = bus_wdata;

    always_comb begin
        data_periph_write = '0;
        if (bus_we && bus_hit) begin
            data_periph_write[word_idx] = 1'b1;
        end
    end

    // read data holds until the next read that hits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_rdata <= '0;
        end else if (bus_re && bus_hit) begin
            bus_rdata <= data_periph_in[word_idx*xlen +: xlen];
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/csr_pkg.sv
source/csr_regs.sv
source/csr_counters.sv
source/periph_mem_interface.sv
source/machine_timer.sv
source/csr_unit.sv
sim/csr_unit_tb.sv
